// File: ant_cfg.svh
`ifndef ANT_CFG_SVH
`define ANT_CFG_SVH

// Coordinate, id and colour widths
`define ANT_X_WIDTH       8
`define ANT_Y_WIDTH       7
`define ANT_ID_WIDTH      3
`define ANT_COLOUR_WIDTH  3

`define ANT_COUNT         8

// Screen in pixels
`define ANT_SCREEN_WIDTH  160
`define ANT_SCREEN_HEIGHT 120

// Sprite is centred on the ant position
`define ANT_SPRITE_WIDTH  3
`define ANT_SPRITE_HEIGHT 3

// Every ant starts here after reset
`define ANT_START_X       10
`define ANT_START_Y       10

`define ANT_COLOUR        3'b110

`endif

// File: ant_bus_pkg.sv
`default_nettype none

`include "ant_cfg.svh"

package ant_bus_pkg;

    // Commands understood by the ant store
    typedef enum logic [2:0] {
        OP_READ_X,
        OP_READ_Y,
        OP_WRITE_X,
        OP_WRITE_Y,
        OP_PLOT
    } ant_opcode_t;

    typedef logic [`ANT_X_WIDTH-1:0]      x_coord_t;
    typedef logic [`ANT_Y_WIDTH-1:0]      y_coord_t;
    typedef logic [`ANT_ID_WIDTH-1:0]     ant_id_t;
    typedef logic [`ANT_COLOUR_WIDTH-1:0] colour_t;

endpackage

`default_nettype wire

// File: ant_fsm_pkg.sv
`default_nettype none

package ant_fsm_pkg;

    typedef enum logic [3:0] {
        DRAW_STANDBY,
        LOAD_X_START,
        LOAD_X_DELAY,
        LOAD_X_WAIT,
        LOAD_Y_START,
        LOAD_Y_DELAY,
        LOAD_Y_WAIT,
        PLOT_START,
        PLOT_DELAY,
        PLOT_WAIT
    } draw_state_t;

    typedef enum logic [3:0] {
        UPDATE_STANDBY,
        UPD_LOAD_X_START,
        UPD_LOAD_X_DELAY,
        UPD_LOAD_X_WAIT,
        UPD_LOAD_Y_START,
        UPD_LOAD_Y_DELAY,
        UPD_LOAD_Y_WAIT,
        MOVE,
        STORE_X_START,
        STORE_X_DELAY,
        STORE_X_WAIT,
        STORE_Y_START,
        STORE_Y_DELAY,
        STORE_Y_WAIT
    } update_state_t;

endpackage

`default_nettype wire

// File: ant_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "ant_cfg.svh"

module ant_store import ant_bus_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic        cmd_valid,
    input  ant_opcode_t cmd_opcode,
    input  ant_id_t     cmd_id,
    input  x_coord_t    cmd_x,
    input  y_coord_t    cmd_y,
    output logic        done,
    output logic [7:0]  result,
    output logic        plot,
    output x_coord_t    plot_x,
    output y_coord_t    plot_y,
    output colour_t     plot_colour
);

    x_coord_t ant_x [`ANT_COUNT];
    y_coord_t ant_y [`ANT_COUNT];

    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int i = 0; i < `ANT_COUNT; i++) begin
                ant_x[i] <= x_coord_t'(`ANT_START_X);
                ant_y[i] <= y_coord_t'(`ANT_START_Y);
            end
            done <= 1'b0;
            plot <= 1'b0;
        end else begin
            done <= cmd_valid;
            plot <= cmd_valid && (cmd_opcode == OP_PLOT);
            if (cmd_valid && (cmd_opcode == OP_WRITE_X)) begin
                ant_x[cmd_id] <= cmd_x;
            end
            if (cmd_valid && (cmd_opcode == OP_WRITE_Y)) begin
                ant_y[cmd_id] <= cmd_y;
            end
        end
    end

    // Read data and pixel are valid together with done
    always_ff @(posedge clock) begin
        if (cmd_valid) begin
            case (cmd_opcode)
                OP_READ_X: result <= ant_x[cmd_id];
                OP_READ_Y: result <= {1'b0, ant_y[cmd_id]};
                OP_PLOT: begin
                    plot_x      <= cmd_x;
                    plot_y      <= cmd_y;
                    plot_colour <= `ANT_COLOUR;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter import ant_bus_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic        draw_start,
    input  ant_opcode_t draw_opcode,
    input  ant_id_t     draw_id,
    input  x_coord_t    draw_x,
    input  y_coord_t    draw_y,
    output logic        draw_finished,
    input  logic        update_start,
    input  ant_opcode_t update_opcode,
    input  ant_id_t     update_id,
    input  x_coord_t    update_x,
    input  y_coord_t    update_y,
    output logic        update_finished,
    output logic [7:0]  result,
    output logic        cmd_valid,
    output ant_opcode_t cmd_opcode,
    output ant_id_t     cmd_id,
    output x_coord_t    cmd_x,
    output y_coord_t    cmd_y,
    input  logic        done,
    input  logic [7:0]  store_result
);

    logic granted;
    logic owner_update;
    logic issued;
    logic draw_start_q;
    logic update_start_q;
    logic draw_fell;
    logic update_fell;
    logic draw_fall;
    logic update_fall;
    logic owner_ready;

    // A fall is kept until served, so a client that waited is not lost
    assign draw_fall   = draw_fell | (draw_start_q & ~draw_start);
    assign update_fall = update_fell | (update_start_q & ~update_start);
    assign owner_ready = owner_update ? update_fall : draw_fall;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            granted        <= 1'b0;
            owner_update   <= 1'b0;
            issued         <= 1'b0;
            draw_start_q   <= 1'b0;
            update_start_q <= 1'b0;
            draw_fell      <= 1'b0;
            update_fell    <= 1'b0;
            cmd_valid      <= 1'b0;
        end else begin
            draw_start_q   <= draw_start;
            update_start_q <= update_start;
            draw_fell      <= draw_fall;
            update_fell    <= update_fall;
            cmd_valid      <= 1'b0;
            if (!granted) begin
                // Update wins a tie
                if (update_start || update_fall) begin
                    granted      <= 1'b1;
                    owner_update <= 1'b1;
                end else if (draw_start || draw_fall) begin
                    granted      <= 1'b1;
                    owner_update <= 1'b0;
                end
            end else if (!issued) begin
                if (owner_ready) begin
                    cmd_valid <= 1'b1;
                    issued    <= 1'b1;
                    if (owner_update) begin
                        update_fell <= 1'b0;
                    end else begin
                        draw_fell <= 1'b0;
                    end
                end
            end else if (done) begin
                granted <= 1'b0;
                issued  <= 1'b0;
            end
        end
    end

    // Owner's command is sampled in the cycle that raises cmd_valid
    always_ff @(posedge clock) begin
        cmd_opcode <= owner_update ? update_opcode : draw_opcode;
        cmd_id     <= owner_update ? update_id : draw_id;
        cmd_x      <= owner_update ? update_x : draw_x;
        cmd_y      <= owner_update ? update_y : draw_y;
    end

    assign draw_finished   = done & issued & ~owner_update;
    assign update_finished = done & issued & owner_update;
    assign result          = store_result;

endmodule

`default_nettype wire

// File: ant_draw.sv
`timescale 1ns/10ps
`default_nettype none

`include "ant_cfg.svh"

module ant_draw import ant_bus_pkg::*, ant_fsm_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic        start,
    input  ant_id_t     id,
    output logic        finished,
    output logic        bus_start,
    output ant_opcode_t bus_opcode,
    output ant_id_t     bus_id,
    output x_coord_t    bus_x,
    output y_coord_t    bus_y,
    input  logic        bus_finished,
    input  logic [7:0]  bus_result
);

    draw_state_t state;
    x_coord_t    corner_x;
    y_coord_t    corner_y;
    logic [1:0]  dx;
    logic [1:0]  dy;

    // Bus start is raised in a START state and held through DELAY
    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= DRAW_STANDBY;
            finished  <= 1'b1;
            bus_start <= 1'b0;
        end else begin
            case (state)
                DRAW_STANDBY: begin
                    if (start) begin
                        bus_id   <= id;
                        dx       <= 2'd0;
                        dy       <= 2'd0;
                        finished <= 1'b0;
                        state    <= LOAD_X_START;
                    end
                end
                LOAD_X_START: begin
                    bus_start  <= 1'b1;
                    bus_opcode <= OP_READ_X;
                    state      <= LOAD_X_DELAY;
                end
                LOAD_X_DELAY: state <= LOAD_X_WAIT;
                LOAD_X_WAIT: begin
                    bus_start <= 1'b0;
                    if (bus_finished) begin
                        // Corner is one pixel left of the centre
                        corner_x <= bus_result - 1'b1;
                        state    <= LOAD_Y_START;
                    end
                end
                LOAD_Y_START: begin
                    bus_start  <= 1'b1;
                    bus_opcode <= OP_READ_Y;
                    state      <= LOAD_Y_DELAY;
                end
                LOAD_Y_DELAY: state <= LOAD_Y_WAIT;
                LOAD_Y_WAIT: begin
                    bus_start <= 1'b0;
                    if (bus_finished) begin
                        corner_y <= bus_result[`ANT_Y_WIDTH-1:0] - 1'b1;
                        state    <= PLOT_START;
                    end
                end
                PLOT_START: begin
                    bus_start  <= 1'b1;
                    bus_opcode <= OP_PLOT;
                    bus_x      <= corner_x + dx;
                    bus_y      <= corner_y + dy;
                    state      <= PLOT_DELAY;
                end
                PLOT_DELAY: state <= PLOT_WAIT;
                PLOT_WAIT: begin
                    bus_start <= 1'b0;
                    if (bus_finished) begin
                        state <= PLOT_START;
                        // dx runs fastest across the row
                        if (dx == `ANT_SPRITE_WIDTH - 1) begin
                            dx <= 2'd0;
                            if (dy == `ANT_SPRITE_HEIGHT - 1) begin
                                finished <= 1'b1;
                                state    <= DRAW_STANDBY;
                            end else begin
                                dy <= dy + 1'b1;
                            end
                        end else begin
                            dx <= dx + 1'b1;
                        end
                    end
                end
                default: state <= DRAW_STANDBY;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: ant_update.sv
`timescale 1ns/10ps
`default_nettype none

`include "ant_cfg.svh"

module ant_update import ant_bus_pkg::*, ant_fsm_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic        start,
    input  ant_id_t     id,
    output logic        finished,
    output logic        bus_start,
    output ant_opcode_t bus_opcode,
    output ant_id_t     bus_id,
    output x_coord_t    bus_x,
    output y_coord_t    bus_y,
    input  logic        bus_finished,
    input  logic [7:0]  bus_result,
    input  logic        move_left,
    input  logic        move_right,
    input  logic        move_up,
    input  logic        move_down
);

    update_state_t state;
    x_coord_t      x_pos;
    y_coord_t      y_pos;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= UPDATE_STANDBY;
            finished  <= 1'b1;
            bus_start <= 1'b0;
        end else begin
            case (state)
                UPDATE_STANDBY: begin
                    if (start) begin
                        bus_id   <= id;
                        finished <= 1'b0;
                        state    <= UPD_LOAD_X_START;
                    end
                end
                UPD_LOAD_X_START: begin
                    bus_start  <= 1'b1;
                    bus_opcode <= OP_READ_X;
                    state      <= UPD_LOAD_X_DELAY;
                end
                UPD_LOAD_X_DELAY: state <= UPD_LOAD_X_WAIT;
                UPD_LOAD_X_WAIT: begin
                    bus_start <= 1'b0;
                    if (bus_finished) begin
                        x_pos <= bus_result;
                        state <= UPD_LOAD_Y_START;
                    end
                end
                UPD_LOAD_Y_START: begin
                    bus_start  <= 1'b1;
                    bus_opcode <= OP_READ_Y;
                    state      <= UPD_LOAD_Y_DELAY;
                end
                UPD_LOAD_Y_DELAY: state <= UPD_LOAD_Y_WAIT;
                UPD_LOAD_Y_WAIT: begin
                    bus_start <= 1'b0;
                    if (bus_finished) begin
                        y_pos <= bus_result[`ANT_Y_WIDTH-1:0];
                        state <= MOVE;
                    end
                end
                MOVE: begin
                    // Opposite requests cancel, and the sprite never leaves the screen
                    if (!(move_left && move_right)) begin
                        if (move_left && x_pos > `ANT_SPRITE_WIDTH / 2) begin
                            x_pos <= x_pos - 1'b1;
                        end else if (move_right &&
                                     x_pos < `ANT_SCREEN_WIDTH - `ANT_SPRITE_WIDTH / 2 - 1) begin
                            x_pos <= x_pos + 1'b1;
                        end
                    end
                    if (!(move_up && move_down)) begin
                        if (move_up && y_pos > `ANT_SPRITE_HEIGHT / 2) begin
                            y_pos <= y_pos - 1'b1;
                        end else if (move_down &&
                                     y_pos < `ANT_SCREEN_HEIGHT - `ANT_SPRITE_HEIGHT / 2 - 1) begin
                            y_pos <= y_pos + 1'b1;
                        end
                    end
                    state <= STORE_X_START;
                end
                STORE_X_START: begin
                    bus_start  <= 1'b1;
                    bus_opcode <= OP_WRITE_X;
                    bus_x      <= x_pos;
                    state      <= STORE_X_DELAY;
                end
                STORE_X_DELAY: state <= STORE_X_WAIT;
                STORE_X_WAIT: begin
                    bus_start <= 1'b0;
                    if (bus_finished) begin
                        state <= STORE_Y_START;
                    end
                end
                STORE_Y_START: begin
                    bus_start  <= 1'b1;
                    bus_opcode <= OP_WRITE_Y;
                    bus_y      <= y_pos;
                    state      <= STORE_Y_DELAY;
                end
                STORE_Y_DELAY: state <= STORE_Y_WAIT;
                STORE_Y_WAIT: begin
                    bus_start <= 1'b0;
                    if (bus_finished) begin
                        finished <= 1'b1;
                        state    <= UPDATE_STANDBY;
                    end
                end
                default: state <= UPDATE_STANDBY;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: ant_engine.sv
`timescale 1ns/10ps
`default_nettype none

module ant_engine import ant_bus_pkg::*; (
    input  logic     clock,
    input  logic     resetn,
    input  logic     draw_start,
    input  ant_id_t  draw_id,
    output logic     draw_finished,
    input  logic     update_start,
    input  ant_id_t  update_id,
    output logic     update_finished,
    input  logic     move_left,
    input  logic     move_right,
    input  logic     move_up,
    input  logic     move_down,
    output logic     plot,
    output x_coord_t plot_x,
    output y_coord_t plot_y,
    output colour_t  plot_colour
);

    // Draw client
    logic        draw_bus_start;
    ant_opcode_t draw_bus_opcode;
    ant_id_t     draw_bus_id;
    x_coord_t    draw_bus_x;
    y_coord_t    draw_bus_y;
    logic        draw_bus_finished;

    // Update client
    logic        update_bus_start;
    ant_opcode_t update_bus_opcode;
    ant_id_t     update_bus_id;
    x_coord_t    update_bus_x;
    y_coord_t    update_bus_y;
    logic        update_bus_finished;

    logic [7:0]  bus_result;

    // Arbiter to store
    logic        cmd_valid;
    ant_opcode_t cmd_opcode;
    ant_id_t     cmd_id;
    x_coord_t    cmd_x;
    y_coord_t    cmd_y;
    logic        cmd_done;
    logic [7:0]  store_result;

    ant_draw ant_draw_inst (
        .clock        (clock),
        .resetn       (resetn),
        .start        (draw_start),
        .id           (draw_id),
        .finished     (draw_finished),
        .bus_start    (draw_bus_start),
        .bus_opcode   (draw_bus_opcode),
        .bus_id       (draw_bus_id),
        .bus_x        (draw_bus_x),
        .bus_y        (draw_bus_y),
        .bus_finished (draw_bus_finished),
        .bus_result   (bus_result)
    );

    ant_update ant_update_inst (
        .clock        (clock),
        .resetn       (resetn),
        .start        (update_start),
        .id           (update_id),
        .finished     (update_finished),
        .bus_start    (update_bus_start),
        .bus_opcode   (update_bus_opcode),
        .bus_id       (update_bus_id),
        .bus_x        (update_bus_x),
        .bus_y        (update_bus_y),
        .bus_finished (update_bus_finished),
        .bus_result   (bus_result),
        .move_left    (move_left),
        .move_right   (move_right),
        .move_up      (move_up),
        .move_down    (move_down)
    );

    bus_arbiter bus_arbiter_inst (
        .clock           (clock),
        .resetn          (resetn),
        .draw_start      (draw_bus_start),
        .draw_opcode     (draw_bus_opcode),
        .draw_id         (draw_bus_id),
        .draw_x          (draw_bus_x),
        .draw_y          (draw_bus_y),
        .draw_finished   (draw_bus_finished),
        .update_start    (update_bus_start),
        .update_opcode   (update_bus_opcode),
        .update_id       (update_bus_id),
        .update_x        (update_bus_x),
        .update_y        (update_bus_y),
        .update_finished (update_bus_finished),
        .result          (bus_result),
        .cmd_valid       (cmd_valid),
        .cmd_opcode      (cmd_opcode),
        .cmd_id          (cmd_id),
        .cmd_x           (cmd_x),
        .cmd_y           (cmd_y),
        .done            (cmd_done),
        .store_result    (store_result)
    );

    ant_store ant_store_inst (
        .clock       (clock),
        .resetn      (resetn),
        .cmd_valid   (cmd_valid),
        .cmd_opcode  (cmd_opcode),
        .cmd_id      (cmd_id),
        .cmd_x       (cmd_x),
        .cmd_y       (cmd_y),
        .done        (cmd_done),
        .result      (store_result),
        .plot        (plot),
        .plot_x      (plot_x),
        .plot_y      (plot_y),
        .plot_colour (plot_colour)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reset spans eight rising edges and is released on a falling edge
    initial begin
        resetn = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

// File: ant_engine_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "ant_cfg.svh"

module ant_engine_properties import ant_bus_pkg::*; (
    input logic     clock,
    input logic     resetn,
    input logic     plot,
    input x_coord_t plot_x,
    input y_coord_t plot_y,
    input colour_t  plot_colour,
    input logic     draw_finished,
    input logic     update_finished
);

    int failures = 0;

    // The display sink takes plot as a single-cycle pulse
    plot_is_pulse: assert property (@(posedge clock) disable iff (!resetn)
        plot |=> !plot)
        else begin
            failures++;
            $error("plot stayed high for two consecutive cycles");
        end

    plot_colour_fixed: assert property (@(posedge clock) disable iff (!resetn)
        plot |-> (plot_colour == `ANT_COLOUR))
        else begin
            failures++;
            $error("plot_colour differs from the sprite colour");
        end

    plot_on_screen: assert property (@(posedge clock) disable iff (!resetn)
        plot |-> ((plot_x < `ANT_SCREEN_WIDTH) && (plot_y < `ANT_SCREEN_HEIGHT)))
        else begin
            failures++;
            $error("plotted pixel lies outside the screen");
        end

    // Both engines sit idle while reset is held
    idle_in_reset: assert property (@(posedge clock)
        !resetn |=> (draw_finished && update_finished))
        else begin
            failures++;
            $error("an engine finished output was low during reset");
        end

endmodule

bind ant_engine ant_engine_properties ant_engine_properties_inst (
    .clock           (clock),
    .resetn          (resetn),
    .plot            (plot),
    .plot_x          (plot_x),
    .plot_y          (plot_y),
    .plot_colour     (plot_colour),
    .draw_finished   (draw_finished),
    .update_finished (update_finished)
);

`default_nettype wire

// File: ant_engine_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ant_cfg.svh"

module ant_engine_tb import ant_bus_pkg::*; ();

    localparam int X_MAX = `ANT_SCREEN_WIDTH - 2;
    localparam int Y_MAX = `ANT_SCREEN_HEIGHT - 2;
    localparam int OP_TIMEOUT = 500;
    // Each operation gets a generous cycle budget, scaled over all draws and updates
    localparam int DRAW_CYCLES = 100;
    localparam int UPDATE_CYCLES = 50;
    localparam int MAX_DRAWS = 40;
    localparam int MAX_UPDATES = 80;
    localparam int WATCHDOG_CYCLES =
        (MAX_DRAWS * DRAW_CYCLES + MAX_UPDATES * UPDATE_CYCLES) * 5 / 2;

    logic     clock;
    logic     resetn;
    logic     draw_start;
    ant_id_t  draw_id;
    logic     draw_finished;
    logic     update_start;
    ant_id_t  update_id;
    logic     update_finished;
    logic     move_left;
    logic     move_right;
    logic     move_up;
    logic     move_down;
    logic     plot;
    x_coord_t plot_x;
    y_coord_t plot_y;
    colour_t  plot_colour;

    int          model_x [`ANT_COUNT];
    int          model_y [`ANT_COUNT];
    int          exp_x [$];
    int          exp_y [$];
    int          plot_count;
    int          total_checks;
    int          total_errors;
    int          assertion_failures;
    int          test_number;
    int          test_checks;
    int          test_errors;
    logic [31:0] lfsr_state;

    tb_clock_gen tb_clock_gen_inst (
        .clock  (clock),
        .resetn (resetn)
    );

    ant_engine ant_engine_inst (
        .clock           (clock),
        .resetn          (resetn),
        .draw_start      (draw_start),
        .draw_id         (draw_id),
        .draw_finished   (draw_finished),
        .update_start    (update_start),
        .update_id       (update_id),
        .update_finished (update_finished),
        .move_left       (move_left),
        .move_right      (move_right),
        .move_up         (move_up),
        .move_down       (move_down),
        .plot            (plot),
        .plot_x          (plot_x),
        .plot_y          (plot_y),
        .plot_colour     (plot_colour)
    );

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Opposite requests cancel, and the centre stays one pixel inside the screen
    function automatic int step_axis(input int pos, input logic dec, input logic inc,
                                     input int hi);
        if (dec && inc) begin
            return pos;
        end else if (dec) begin
            return (pos > 1) ? pos - 1 : pos;
        end else if (inc) begin
            return (pos < hi) ? pos + 1 : pos;
        end
        return pos;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        total_checks++;
        assert (expected == actual) else begin
            $display("FAIL at %0d ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            total_errors++;
        end
    endtask

    task automatic expect_sprite(input int id);
        for (int dy = 0; dy < `ANT_SPRITE_HEIGHT; dy++) begin
            for (int dx = 0; dx < `ANT_SPRITE_WIDTH; dx++) begin
                exp_x.push_back(model_x[id] - 1 + dx);
                exp_y.push_back(model_y[id] - 1 + dy);
            end
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (!(draw_finished && update_finished) && cycles < OP_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!(draw_finished && update_finished)) begin
            $display("Engines did not return to standby within %0d cycles", OP_TIMEOUT);
            total_errors++;
        end
    endtask

    task automatic close_draw(input int base);
        check_value("plot pulses", base + 9, plot_count);
        exp_x.delete();
        exp_y.delete();
    endtask

    task automatic draw_ant(input int id);
        int base;
        @(negedge clock);
        base = plot_count;
        expect_sprite(id);
        draw_id = ant_id_t'(id);
        draw_start = 1'b1;
        @(negedge clock);
        draw_start = 1'b0;
        wait_idle();
        close_draw(base);
    endtask

    task automatic update_ant(input int id, input logic l, input logic r,
                              input logic u, input logic d);
        @(negedge clock);
        update_id = ant_id_t'(id);
        move_left = l;
        move_right = r;
        move_up = u;
        move_down = d;
        update_start = 1'b1;
        @(negedge clock);
        update_start = 1'b0;
        wait_idle();
        {move_left, move_right, move_up, move_down} = 4'b0000;
        model_x[id] = step_axis(model_x[id], l, r, X_MAX);
        model_y[id] = step_axis(model_y[id], u, d, Y_MAX);
    endtask

    task automatic end_test(input string name);
        int failures;
        failures = ant_engine_inst.ant_engine_properties_inst.failures;
        total_errors += failures - assertion_failures;
        assertion_failures = failures;
        $display("Test %0d %s: %0d checks, %0d errors", test_number, name,
                 total_checks - test_checks, total_errors - test_errors);
        test_number++;
        test_checks = total_checks;
        test_errors = total_errors;
    endtask

    // Plot outputs are stable at the falling edge
    always @(negedge clock) begin : plot_monitor
        int ex;
        int ey;
        if (resetn && plot) begin
            plot_count++;
            if (exp_x.size() == 0) begin
                $display("Plot pulse at %0d ns with no pixel left to draw", $time);
                total_errors++;
            end else begin
                ex = exp_x.pop_front();
                ey = exp_y.pop_front();
                check_value("plot_x", ex, plot_x);
                check_value("plot_y", ey, plot_y);
            end
        end
    end

    initial begin
        int base;
        int rand_id;
        int moves;
        draw_start = 1'b0;
        draw_id = '0;
        update_start = 1'b0;
        update_id = '0;
        {move_left, move_right, move_up, move_down} = 4'b0000;
        lfsr_state = 32'h29f1;
        plot_count = 0;
        total_checks = 0;
        total_errors = 0;
        assertion_failures = 0;
        test_number = 1;
        test_checks = 0;
        test_errors = 0;
        for (int ant = 0; ant < `ANT_COUNT; ant++) begin
            model_x[ant] = `ANT_START_X;
            model_y[ant] = `ANT_START_Y;
        end
        wait (resetn === 1'b1);
        @(negedge clock);

        for (int ant = 0; ant < `ANT_COUNT; ant++) begin
            draw_ant(ant);
        end
        end_test("reset positions");

        update_ant(0, 1'b0, 1'b1, 1'b0, 1'b1);
        draw_ant(0);
        end_test("move right and down");

        update_ant(2, 1'b1, 1'b1, 1'b1, 1'b1);
        draw_ant(2);
        repeat (12) update_ant(2, 1'b1, 1'b0, 1'b0, 1'b0);
        draw_ant(2);
        repeat (12) update_ant(2, 1'b0, 1'b0, 1'b1, 1'b0);
        draw_ant(2);
        end_test("edge clamping");

        // Both engines request in the same cycle
        @(negedge clock);
        base = plot_count;
        expect_sprite(5);
        draw_id = ant_id_t'(5);
        update_id = ant_id_t'(6);
        move_right = 1'b1;
        move_up = 1'b1;
        draw_start = 1'b1;
        update_start = 1'b1;
        @(negedge clock);
        draw_start = 1'b0;
        update_start = 1'b0;
        wait_idle();
        {move_left, move_right, move_up, move_down} = 4'b0000;
        close_draw(base);
        model_x[6] = step_axis(model_x[6], 1'b0, 1'b1, X_MAX);
        model_y[6] = step_axis(model_y[6], 1'b1, 1'b0, Y_MAX);
        draw_ant(6);
        end_test("concurrent draw and update");

        for (int n = 0; n < 40; n++) begin
            random_bits(`ANT_ID_WIDTH, rand_id);
            random_bits(4, moves);
            update_ant(rand_id, moves[3], moves[2], moves[1], moves[0]);
        end
        for (int ant = 0; ant < `ANT_COUNT; ant++) begin
            draw_ant(ant);
        end
        end_test("random updates");

        $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
ant_bus_pkg.sv
ant_fsm_pkg.sv
ant_store.sv
bus_arbiter.sv
ant_draw.sv
ant_update.sv
ant_engine.sv
tb_clock_gen.sv
ant_engine_properties.sv
ant_engine_tb.sv
